// File: sources.f
rtl/ilk_rx_pkg.sv
rtl/ilk_burst_decoder.sv
rtl/ilk_to_avalon_adapter.sv
rtl/avl_rx_stats.sv
rtl/ilk_rx_top.sv
tb/tb_ilk_rx.sv

// File: run_sim.sh
#!/bin/sh
# build and run the Interlaken rx testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_ilk_rx -f sources.f -o sim_tb; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "All checks passed" sim.log; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi

// File: tb/tb_ilk_rx.sv
`timescale 1ns/1ps
/*
 * Testbench for the Interlaken receive boundary
 * table of lane groups with random idles
 * a reference model fills the expected beat queue
 * and a monitor compares every avl_out beat
 */
module tb_ilk_rx
   import ilk_rx_pkg::*;
;

   localparam int CLK_PERIOD = 40;
   localparam int CNT_W      = 16;

   // one stimulus row with slot 0 arriving first
   typedef struct packed {
      ilk_lane_t s0;
      ilk_lane_t s1;
   } group_t;

   logic             clk = 1'b0;
   logic             arst_n = 1'b0;
   ilk_lane_t        lanes [ILK_LANES];
   avl_beat_t        avl_out;
   logic [CNT_W-1:0] pkt_count;
   logic [CNT_W-1:0] err_count;
   logic [CNT_W-1:0] beat_count;

   group_t           rows[$];         // stimulus table including idles
   string            row_names[$];
   avl_beat_t        exp_q[$];        // expected beats in order
   string            exp_name_q[$];
   int               tbl_len = 0;     // rows from the table itself
   int               idle_cnt = 0;    // random idles added
   int               word_idx = 0;
   logic             table_ready = 1'b0;
   logic [CNT_W-1:0] exp_pkt = '0;
   logic [CNT_W-1:0] exp_err = '0;
   logic [CNT_W-1:0] exp_beats = '0;

   ilk_rx_top #(
      .CNT_W (CNT_W)
   ) u_dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .lanes      (lanes),
      .avl_out    (avl_out),
      .pkt_count  (pkt_count),
      .err_count  (err_count),
      .beat_count (beat_count)
   );

   initial begin
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic abort_run();
      $display("Checks failed");
      $fatal(1, "run stopped at first error");
   endtask

   // unique payload per data word
   function automatic logic [ILK_WORD_W-1:0] data_word(input logic [31:0] k);
      return {16'hda7a, k[15:0], ~k};
   endfunction

   function automatic ilk_lane_t data_lane();
      ilk_lane_t l;
      l            = '0;
      l.valid      = 1'b1;
      l.word.raw   = data_word(word_idx);
      word_idx     = word_idx + 1;
      return l;
   endfunction

   function automatic ilk_lane_t ctl_lane(input logic sop, input logic [3:0] eop);
      ilk_lane_t l;
      ilk_ctl_t  c;
      c         = '0;
      c.burst   = 1'b1;
      c.sop     = sop;
      c.eopbits = eop;
      c.channel = 8'h05;        // ignored by the core
      c.crc24   = 24'h5a5a5a;
      l         = '0;
      l.valid   = 1'b1;
      l.ctl     = 1'b1;
      l.word.ctl = c;
      return l;
   endfunction

   task automatic push_row(input string name, input group_t g);
      rows.push_back(g);
      row_names.push_back(name);
      tbl_len = tbl_len + 1;
      if ($urandom_range(3) == 0) begin   // idle must not release anything
         rows.push_back('0);
         row_names.push_back("random_idle");
         idle_cnt = idle_cnt + 1;
      end
   endtask

   // control word in slot 0 with an optional data word behind it
   task automatic add_ctl(input string name, input logic sop, input logic [3:0] eop,
                          input logic with_data);
      group_t g;
      g.s0 = ctl_lane(sop, eop);
      g.s1 = with_data ? data_lane() : '0;
      push_row(name, g);
   endtask

   task automatic add_data(input string name, input int n);
      group_t g;
      g.s0 = data_lane();
      g.s1 = (n == 2) ? data_lane() : '0;
      push_row(name, g);
   endtask

   task automatic add_idle(input string name);
      push_row(name, '0);
   endtask

   task automatic build_table();
      int b;
      add_ctl("drop_eop", 1'b0, EOP_BYTES_BASE, 1'b0);   // nothing held so the eop is dropped
      add_ctl("multi_beat", 1'b1, EOP_NONE, 1'b0);
      add_data("multi_beat", 2);
      add_data("multi_beat", 2);
      add_data("multi_beat", 2);
      add_idle("multi_beat");
      add_ctl("multi_beat", 1'b0, EOP_BYTES_BASE, 1'b0);
      for (b = 1; b < 8; b++) begin
         add_ctl($sformatf("bytes_two_%0d", b), 1'b1, EOP_NONE, 1'b0);
         add_data($sformatf("bytes_two_%0d", b), 2);
         add_ctl($sformatf("bytes_two_%0d", b), 1'b0, EOP_BYTES_BASE | 4'(b), 1'b0);
         add_ctl($sformatf("bytes_one_%0d", b), 1'b1, EOP_NONE, 1'b1);   // data in slot 1
         add_idle($sformatf("bytes_one_%0d", b));
         add_ctl($sformatf("bytes_one_%0d", b), 1'b0, EOP_BYTES_BASE | 4'(b), 1'b0);
      end
      add_ctl("err_code", 1'b1, EOP_NONE, 1'b0);
      add_data("err_code", 2);
      add_data("err_code", 1);       // one-word beat mid packet
      add_ctl("err_code", 1'b0, EOP_ERR, 1'b0);
      add_ctl("undef_code", 1'b1, EOP_NONE, 1'b1);
      add_ctl("undef_code", 1'b0, 4'b0101, 1'b0);
      add_ctl("back_to_back", 1'b1, EOP_NONE, 1'b0);
      add_data("back_to_back", 2);
      add_ctl("back_to_back", 1'b1, EOP_BYTES_BASE | 4'd3, 1'b1);   // close and reopen
      add_data("back_to_back", 1);
      add_ctl("back_to_back", 1'b0, EOP_BYTES_BASE, 1'b0);
   endtask

   // avalon view of a released beat
   function automatic avl_beat_t expect_avl(input logic sop, input logic [1:0] n,
                                            input logic [3:0] eopbits,
                                            input logic [BEAT_W-1:0] data);
      avl_beat_t  e;
      logic [4:0] used;    // valid bytes out of the 16 in a beat
      e       = '0;
      e.valid = 1'b1;
      e.sop   = sop;
      e.data  = data;
      used    = {n, 3'b000};   // every word full
      if (eopbits == EOP_NONE) begin
         e.empty = 4'(5'd16 - used);
      end else if (eopbits[3]) begin
         e.eop = 1'b1;
         if (eopbits[2:0] != 3'd0) begin
            used = used - 5'd8 + {2'b00, eopbits[2:0]};   // last word only partly filled
         end
         e.empty = 4'(5'd16 - used);
      end else begin
         e.eop   = 1'b1;   // EOP_ERR and undefined codes
         e.error = 1'b1;
      end
      return e;
   endfunction

   // walks the table once and holds each beat until the next valid slot 0
   task automatic run_model();
      int                i;
      logic              held_v;
      logic              held_sop;
      logic              pend;
      logic              sop_now;
      logic [1:0]        held_n;
      logic [1:0]        n;
      logic [3:0]        rel_eop;
      logic [BEAT_W-1:0] held_d;
      logic [BEAT_W-1:0] d;
      string             held_name;
      avl_beat_t         e;
      held_v    = 1'b0;
      held_sop  = 1'b0;
      pend      = 1'b0;
      held_n    = 2'd0;
      held_d    = '0;
      held_name = "";
      for (i = 0; i < rows.size(); i++) begin
         if (rows[i].s0.valid) begin
            rel_eop = rows[i].s0.ctl ? rows[i].s0.word.ctl.eopbits : EOP_NONE;
            if (held_v) begin
               e = expect_avl(held_sop, held_n, rel_eop, held_d);
               exp_q.push_back(e);
               exp_name_q.push_back(held_name);
               exp_beats = exp_beats + CNT_W'(1);
               if (e.eop && e.error) begin
                  exp_err = exp_err + CNT_W'(1);
               end
               if (e.eop && !e.error) begin
                  exp_pkt = exp_pkt + CNT_W'(1);
               end
            end
            n       = 2'd0;
            d       = '0;
            sop_now = pend | (rows[i].s0.ctl & rows[i].s0.word.ctl.sop);
            if (!rows[i].s0.ctl) begin
               d[BEAT_W-1 -: ILK_WORD_W] = rows[i].s0.word.raw;
               n = 2'd1;
            end
            if (rows[i].s1.valid) begin
               if (n == 2'd0) begin
                  d[BEAT_W-1 -: ILK_WORD_W] = rows[i].s1.word.raw;
               end else begin
                  d[ILK_WORD_W-1:0] = rows[i].s1.word.raw;
               end
               n = n + 2'd1;
            end
            held_v = (n != 2'd0);
            if (held_v) begin
               held_sop  = sop_now;
               held_n    = n;
               held_d    = d;
               held_name = row_names[i];
               pend      = 1'b0;
            end else begin
               pend = sop_now;   // sop waits for the next data
            end
         end
      end
   endtask

   task automatic check_avl_beat(input string name, input avl_beat_t exp,
                                 input avl_beat_t act, input bit with_data);
      avl_beat_t mask;
      mask = '1;
      if (!with_data) begin
         mask.data = '0;   // data field left out of the compare
      end
      if ((act & mask) !== (exp & mask)) begin
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_counts(input string name,
                               input logic [CNT_W-1:0] exp_p, input logic [CNT_W-1:0] exp_e,
                               input logic [CNT_W-1:0] exp_b, input logic [CNT_W-1:0] act_p,
                               input logic [CNT_W-1:0] act_e, input logic [CNT_W-1:0] act_b);
      if (act_p !== exp_p) begin
         $display("FAIL %s pkt_count: expected %0d, actual %0d", name, exp_p, act_p);
         abort_run();
      end else if (act_e !== exp_e) begin
         $display("FAIL %s err_count: expected %0d, actual %0d", name, exp_e, act_e);
         abort_run();
      end else if (act_b !== exp_b) begin
         $display("FAIL %s beat_count: expected %0d, actual %0d", name, exp_b, act_b);
         abort_run();
      end
   endtask

   // outputs settle after the rising edge so sample on the falling one
   always @(negedge clk) begin
      if (arst_n && avl_out.valid) begin
         if (exp_q.size() == 0) begin
            $display("avl_out gave a beat that the model did not expect");
            abort_run();
         end else begin
            check_avl_beat(exp_name_q.pop_front(), exp_q.pop_front(), avl_out, 1'b1);
         end
      end
   end

   initial begin : watchdog
      int wd_cycles;
      wait (table_ready);
      wd_cycles = tbl_len + idle_cnt + 20;
      repeat (wd_cycles) @(posedge clk);
      $display("timeout, run did not end within %0d cycles", wd_cycles);
      abort_run();
   end

   initial begin : stimulus
      int i;
      lanes[0] = '0;
      lanes[1] = '0;
      arst_n   = 1'b0;
      void'($urandom(53));
      build_table();
      run_model();
      table_ready = 1'b1;
      repeat (5) @(posedge clk);
      #2 arst_n = 1'b1;
      @(negedge clk);
      check_avl_beat("reset_state", '0, avl_out, 1'b0);
      check_counts("reset_state", '0, '0, '0, pkt_count, err_count, beat_count);
      for (i = 0; i < rows.size(); i++) begin
         @(posedge clk);
         #2;
         lanes[0] = rows[i].s0;
         lanes[1] = rows[i].s1;
      end
      @(posedge clk);
      #2;
      lanes[0] = '0;
      lanes[1] = '0;
      repeat (4) @(posedge clk);   // decoder, adapter and counters drain
      @(negedge clk);
      check_counts("final_counts", exp_pkt, exp_err, exp_beats,
                   pkt_count, err_count, beat_count);
      if (exp_q.size() != 0) begin
         $display("%0d expected beats never appeared on avl_out", exp_q.size());
         abort_run();
      end else begin
         $display("All checks passed");
         $finish;
      end
   end

endmodule

// File: rtl/ilk_rx_top.sv
`timescale 1ns/1ps
/*
 * Interlaken receive boundary, top level
 * burst decoder -> avalon adapter -> statistics
 */
module ilk_rx_top
   import ilk_rx_pkg::*;
#(
   parameter int CNT_W = 16   // statistics counter width
) (
   input  logic             clk,
   input  logic             arst_n,
   input  ilk_lane_t        lanes [ILK_LANES],   // slot 0 arrives first
   output avl_beat_t        avl_out,
   output logic [CNT_W-1:0] pkt_count,
   output logic [CNT_W-1:0] err_count,
   output logic [CNT_W-1:0] beat_count
);

   ilk_beat_t dec_beat;   // held beat with its eop status

   ilk_burst_decoder u_decoder (
      .clk    (clk),
      .arst_n (arst_n),
      .lanes  (lanes),
      .beat   (dec_beat)
   );

   // registered, adds one cycle
   ilk_to_avalon_adapter u_adapter (
      .clk    (clk),
      .arst_n (arst_n),
      .ilk    (dec_beat),
      .avl    (avl_out)
   );

   avl_rx_stats #(
      .CNT_W (CNT_W)
   ) u_stats (
      .clk        (clk),
      .arst_n     (arst_n),
      .avl        (avl_out),
      .pkt_count  (pkt_count),
      .err_count  (err_count),
      .beat_count (beat_count)
   );

endmodule

// File: rtl/avl_rx_stats.sv
`timescale 1ns/1ps
/*
 * Avalon-ST receive statistics
 * saturating counters for good packets, error packets and beats
 */
module avl_rx_stats
   import ilk_rx_pkg::*;
#(
   parameter int CNT_W = 16
) (
   input  logic             clk,
   input  logic             arst_n,
   input  avl_beat_t        avl,
   output logic [CNT_W-1:0] pkt_count,
   output logic [CNT_W-1:0] err_count,
   output logic [CNT_W-1:0] beat_count
);

   logic good_eop;   // packet closed cleanly
   logic bad_eop;    // packet closed with error

   // hold at all ones
   function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] v);
      return (&v) ? v : v + CNT_W'(1);
   endfunction

   assign good_eop = avl.valid & avl.eop & ~avl.error;
   assign bad_eop  = avl.valid & avl.eop & avl.error;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pkt_count  <= '0;
         err_count  <= '0;
         beat_count <= '0;
      end else begin
         if (avl.valid) begin
            beat_count <= sat_inc(beat_count);
         end
         if (good_eop) begin
            pkt_count <= sat_inc(pkt_count);
         end
         if (bad_eop) begin
            err_count <= sat_inc(err_count);
         end
      end
   end

endmodule

// File: rtl/ilk_to_avalon_adapter.sv
`timescale 1ns/1ps
/*
 * Interlaken to Avalon-ST adapter
 * maps word count and eop code to avalon eop, error and empty,
 * registered once on the way out
 */
module ilk_to_avalon_adapter
   import ilk_rx_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  ilk_beat_t ilk,
   output avl_beat_t avl
);

   logic              in_ok;        // valid with 1 or 2 words
   logic              one_word;
   logic [3:0]        byte_cnt;     // valid bytes in last word, 1..8
   logic [3:0]        empty_two;    // empty for a two-word beat

   logic              nxt_valid;
   logic              nxt_sop;
   logic              nxt_eop;
   logic              nxt_error;
   logic [3:0]        nxt_empty;

   logic              q_valid;
   logic              q_sop;
   logic              q_eop;
   logic              q_error;
   logic [3:0]        q_empty;
   logic [BEAT_W-1:0] q_data;

   assign in_ok    = ilk.valid & ((ilk.num_valid == 2'd1) | (ilk.num_valid == 2'd2));
   assign one_word = (ilk.num_valid == 2'd1);

   // code 1000 means a full last word
   assign byte_cnt  = (ilk.eopbits[2:0] == 3'd0) ? BYTES_PER_WORD : {1'b0, ilk.eopbits[2:0]};
   assign empty_two = BYTES_PER_WORD - byte_cnt;

   always_comb begin
      nxt_valid = 1'b0;
      nxt_sop   = 1'b0;
      nxt_eop   = 1'b0;
      nxt_error = 1'b0;
      nxt_empty = 4'd0;
      if (in_ok) begin
         nxt_valid = 1'b1;
         nxt_sop   = ilk.sop;
         case (ilk.eopbits)
            EOP_NONE: begin
               // mid packet, a one-word beat leaves the lower word empty
               nxt_empty = one_word ? BYTES_PER_WORD : 4'd0;
            end
            EOP_ERR: begin
               nxt_eop   = 1'b1;
               nxt_error = 1'b1;
            end
            default: begin
               nxt_eop = 1'b1;
               if ((ilk.eopbits & EOP_BYTES_BASE) == EOP_BYTES_BASE) begin
                  nxt_empty = one_word ? empty_two + BYTES_PER_WORD : empty_two;
               end else begin
                  nxt_error = 1'b1;             // undefined code, treat as error
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         q_valid <= 1'b0;
         q_sop   <= 1'b0;
         q_eop   <= 1'b0;
         q_error <= 1'b0;
         q_empty <= 4'd0;
      end else begin
         q_valid <= nxt_valid;
         q_sop   <= nxt_sop;
         q_eop   <= nxt_eop;
         q_error <= nxt_error;
         q_empty <= nxt_empty;
      end
   end

   always_ff @(posedge clk) begin
      q_data <= ilk.data;   // data passes straight through
   end

   always_comb begin
      avl.valid = q_valid;
      avl.sop   = q_sop;
      avl.eop   = q_eop;
      avl.error = q_error;
      avl.empty = q_empty;
      avl.data  = q_data;
   end

endmodule

// File: rtl/ilk_burst_decoder.sv
`timescale 1ns/1ps
/*
 * Interlaken burst decoder
 * splits control from data words, aligns data to the upper half
 * and holds each beat until the next group tells whether it ends a packet
 */
module ilk_burst_decoder
   import ilk_rx_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  ilk_lane_t lanes [ILK_LANES],
   output ilk_beat_t beat
);

   // group classification
   ilk_ctl_t          ctl0;          // control view of slot 0
   logic              is_ctl0;
   logic              is_data0;
   logic              is_data1;
   logic              release_grp;   // any valid slot 0 releases the held beat

   // beat formed from the current group
   logic              grp_sop;
   logic [1:0]        grp_num;
   logic [BEAT_W-1:0] grp_data;
   logic [3:0]        rel_eopbits;

   // held beat, waiting for its eop status
   logic              held_valid;
   logic              held_sop;
   logic [1:0]        held_num;
   logic [BEAT_W-1:0] held_data;
   logic              sop_pending;   // sop seen with no data in its group

   // output register
   logic              out_valid;
   logic              out_sop;
   logic [1:0]        out_num;
   logic [3:0]        out_eopbits;
   logic [BEAT_W-1:0] out_data;

   assign ctl0     = lanes[0].word.ctl;
   assign is_ctl0  = lanes[0].valid & lanes[0].ctl;
   assign is_data0 = lanes[0].valid & ~lanes[0].ctl;
   assign is_data1 = lanes[1].valid & ~lanes[1].ctl;   // ctl never legal in slot 1

   assign release_grp = lanes[0].valid;

   assign grp_num = {1'b0, is_data0} + {1'b0, is_data1};
   assign grp_sop = sop_pending | (is_ctl0 & ctl0.sop);

   // eop status handed to the beat being released
   assign rel_eopbits = is_ctl0 ? ctl0.eopbits : EOP_NONE;

   always_comb begin
      grp_data = '0;
      if (is_data0) begin
         grp_data[BEAT_W-1 -: ILK_WORD_W] = lanes[0].word.raw;
         if (is_data1) begin
            grp_data[ILK_WORD_W-1:0] = lanes[1].word.raw;
         end
      end else if (is_data1) begin
         // slot 0 was control, shift data up
         grp_data[BEAT_W-1 -: ILK_WORD_W] = lanes[1].word.raw;
      end
   end

   // sop carried over when the sop control word had no data behind it
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sop_pending <= 1'b0;
      end else if (grp_num != 2'd0) begin
         sop_pending <= 1'b0;                  // consumed by this group
      end else if (is_ctl0 && ctl0.sop) begin
         sop_pending <= 1'b1;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         held_valid <= 1'b0;
      end else if (release_grp) begin
         held_valid <= (grp_num != 2'd0);      // old beat leaves, new one takes its place
      end
   end

   always_ff @(posedge clk) begin
      if (release_grp) begin
         held_sop  <= grp_sop;
         held_num  <= grp_num;
         held_data <= grp_data;
      end
   end

   // released beat, one clock after the releasing group
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid   <= 1'b0;
         out_sop     <= 1'b0;
         out_num     <= 2'd0;
         out_eopbits <= EOP_NONE;
      end else begin
         out_valid <= release_grp & held_valid;
         if (release_grp) begin
            out_sop     <= held_sop;
            out_num     <= held_num;
            out_eopbits <= rel_eopbits;   // eop of a lone control word with nothing held is dropped
         end
      end
   end

   always_ff @(posedge clk) begin
      if (release_grp) begin
         out_data <= held_data;
      end
   end

   always_comb begin
      beat.valid     = out_valid;
      beat.sop       = out_sop;
      beat.num_valid = out_num;
      beat.eopbits   = out_eopbits;
      beat.data      = out_data;
   end

endmodule

// File: rtl/ilk_rx_pkg.sv
/*
 * Interlaken receive package
 * word and control-word views, lane slot, beat bundles
 * and the eop code points shared by the rx path
 */
package ilk_rx_pkg;

   localparam int ILK_LANES   = 2;    // words per clock, fixed
   localparam int ILK_WORD_W  = 64;
   localparam int BEAT_W      = ILK_LANES * ILK_WORD_W;

   localparam logic [3:0] BYTES_PER_WORD = 4'd8;

   // eop code points, carried in control word eopbits
   localparam logic [3:0] EOP_NONE       = 4'b0000;  // packet continues
   localparam logic [3:0] EOP_ERR        = 4'b0001;  // eop with error
   localparam logic [3:0] EOP_BYTES_BASE = 4'b1000;  // 1xxx, xxx = bytes in last word (0 -> 8)

   // control word layout, msb first
   typedef struct packed {
      logic        burst;       // burst/idle type flag
      logic        sop;         // next data starts a packet
      logic [3:0]  eopbits;     // closes the previous burst
      logic [1:0]  rsvd_a;
      logic [7:0]  channel;     // decoded but unused here
      logic [23:0] rsvd_b;
      logic [23:0] crc24;       // not checked in this core
   } ilk_ctl_t;

   // one 64-bit word, read as data or as control depending on the framing flag
   typedef union packed {
      logic [ILK_WORD_W-1:0] raw;
      ilk_ctl_t              ctl;
   } ilk_word_u;

   // one word slot of the incoming group
   typedef struct packed {
      logic      valid;
      logic      ctl;           // framing flag, 1 = control word
      ilk_word_u word;
   } ilk_lane_t;

   // decoder output, interlaken side of the adapter
   typedef struct packed {
      logic              valid;
      logic              sop;
      logic [1:0]        num_valid;   // 1 or 2 words
      logic [3:0]        eopbits;
      logic [BEAT_W-1:0] data;        // first word in upper half
   } ilk_beat_t;

   // avalon-st beat
   typedef struct packed {
      logic              valid;
      logic              sop;
      logic              eop;
      logic              error;
      logic [3:0]        empty;       // unused bytes in the beat
      logic [BEAT_W-1:0] data;
   } avl_beat_t;

endpackage
